/* rtl/acq_pkg.sv */
// ------------------
// Shared widths, register map, pattern codes and sample-period table
// for the channel acquisition front end
// ------------------
package acq_pkg;

	localparam int sample_w = 24;	// ADC sample width
	localparam int axil_aw  = 4;	// AXI4-Lite byte address width
	localparam int axil_dw  = 32;

	// Register byte offsets
	localparam logic [axil_aw-1:0] reg_ctrl    = 4'h0;
	localparam logic [axil_aw-1:0] reg_fix     = 4'h4;
	localparam logic [axil_aw-1:0] reg_tp_base = 4'h8;
	localparam logic [axil_aw-1:0] reg_tp_step = 4'hc;

	// ------------------
	// Pattern codes in CTRL[7:0]
	localparam logic [7:0] tp_live  = 8'd0;
	localparam logic [7:0] tp_ident = 8'd1;
	localparam logic [7:0] tp_ramp  = 8'd2;
	localparam logic [7:0] tp_fixed = 8'd3;

	localparam logic [sample_w-1:0] tp_marker = 24'h555555;	// Any other code

	// Sample code to period in clock cycles, full hardware scale
	function automatic logic [23:0] tp_period_base(input logic [7:0] code);
		logic [23:0] period;
		case (code)
			8'd20:   period = 24'd50_000;
			8'd10:   period = 24'd100_000;
			8'd5:    period = 24'd200_000;
			8'd2:    period = 24'd500_000;
			8'd1:    period = 24'd1_000_000;
			default: period = 24'd50_000;	// Unknown code falls back to fastest rate
		endcase
		return period;
	endfunction

endpackage

/* rtl/acq_cfg_regs.sv */
// ------------------
// AXI4-Lite slave with the channel configuration registers
// Fields go straight from the register flops to the datapath
// ------------------
`timescale 1ns/1ps

module acq_cfg_regs (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	// Write address and data
	input  logic [acq_pkg::axil_aw-1:0]  s_awaddr,
	input  logic                         s_awvalid,
	output logic                         s_awready,
	input  logic [acq_pkg::axil_dw-1:0]  s_wdata,
	input  logic [acq_pkg::axil_dw/8-1:0] s_wstrb,
	input  logic                         s_wvalid,
	output logic                         s_wready,
	// Write response
	output logic [1:0]                   s_bresp,
	output logic                         s_bvalid,
	input  logic                         s_bready,
	// Read
	input  logic [acq_pkg::axil_aw-1:0]  s_araddr,
	input  logic                         s_arvalid,
	output logic                         s_arready,
	output logic [acq_pkg::axil_dw-1:0]  s_rdata,
	output logic [1:0]                   s_rresp,
	output logic                         s_rvalid,
	input  logic                         s_rready,
	// Configuration fields
	output logic [7:0]                   cfg_ad_tp,
	output logic [7:0]                   cfg_sample,
	output logic [5:0]                   mod_id,
	output logic [23:0]                  cfg_ad_fix,
	output logic [23:0]                  cfg_tp_base,
	output logic [7:0]                   cfg_tp_step
);

	logic                        wr_go;
	logic                        wr_hs;
	logic                        rd_go;
	logic [acq_pkg::axil_dw-1:0] rd_word;

	// One transaction in flight at a time, writes win a tie
	assign wr_go = s_awvalid & s_wvalid & ~s_awready & ~s_bvalid & ~s_arready & ~s_rvalid;
	assign rd_go = s_arvalid & ~s_arready & ~s_rvalid & ~s_bvalid & ~s_awready & ~wr_go;
	assign wr_hs = s_awready & s_awvalid & s_wvalid;

	assign s_wready = s_awready;	// AW and W accepted together
	assign s_bresp  = 2'b00;	// Always OKAY
	assign s_rresp  = 2'b00;

	// ------------------
	// Write path
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			s_awready   <= 1'b0;
			s_bvalid    <= 1'b0;
			cfg_ad_tp   <= '0;
			cfg_sample  <= '0;
			mod_id      <= '0;
			cfg_ad_fix  <= '0;
			cfg_tp_base <= '0;
			cfg_tp_step <= '0;
		end else begin
			s_awready <= wr_go;
			if (wr_hs)
				s_bvalid <= 1'b1;
			else if (s_bready)
				s_bvalid <= 1'b0;

			if (wr_hs) begin
				case ({s_awaddr[3:2], 2'b00})	// Low address bits ignored
					acq_pkg::reg_ctrl: begin
						if (s_wstrb[0]) cfg_ad_tp  <= s_wdata[7:0];
						if (s_wstrb[1]) cfg_sample <= s_wdata[15:8];
						if (s_wstrb[2]) mod_id     <= s_wdata[21:16];
					end
					acq_pkg::reg_fix: begin
						if (s_wstrb[0]) cfg_ad_fix[7:0]   <= s_wdata[7:0];
						if (s_wstrb[1]) cfg_ad_fix[15:8]  <= s_wdata[15:8];
						if (s_wstrb[2]) cfg_ad_fix[23:16] <= s_wdata[23:16];
					end
					acq_pkg::reg_tp_base: begin
						if (s_wstrb[0]) cfg_tp_base[7:0]   <= s_wdata[7:0];
						if (s_wstrb[1]) cfg_tp_base[15:8]  <= s_wdata[15:8];
						if (s_wstrb[2]) cfg_tp_base[23:16] <= s_wdata[23:16];
					end
					acq_pkg::reg_tp_step: begin
						if (s_wstrb[0]) cfg_tp_step <= s_wdata[7:0];
					end
					default: ;
				endcase
			end
		end
	end

	// ------------------
	// Read path
	always_comb begin
		rd_word = '0;
		case ({s_araddr[3:2], 2'b00})
			acq_pkg::reg_ctrl:    rd_word = {10'h0, mod_id, cfg_sample, cfg_ad_tp};
			acq_pkg::reg_fix:     rd_word = {8'h0, cfg_ad_fix};
			acq_pkg::reg_tp_base: rd_word = {8'h0, cfg_tp_base};
			acq_pkg::reg_tp_step: rd_word = {24'h0, cfg_tp_step};
			default:              rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			s_arready <= 1'b0;
			s_rvalid  <= 1'b0;
			s_rdata   <= '0;
		end else begin
			s_arready <= rd_go;
			if (s_arready & s_arvalid) begin
				s_rvalid <= 1'b1;
				s_rdata  <= rd_word;
			end else if (s_rready) begin
				s_rvalid <= 1'b0;	// Held until the host takes it
			end
		end
	end

endmodule

/* rtl/ad_tp.sv */
// ------------------
// Test pattern source, one word per sample period
// Period restarts on the external sync pulse
// ------------------
`timescale 1ns/1ps

module ad_tp #(
	parameter int period_div = 1	// Shrinks every table period
) (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  logic                         syn_vld,
	input  logic [7:0]                   cfg_sample,
	input  logic [7:0]                   cfg_ad_tp,
	input  logic [5:0]                   mod_id,
	input  logic [23:0]                  cfg_ad_fix,
	input  logic [23:0]                  cfg_tp_base,
	input  logic [7:0]                   cfg_tp_step,
	output logic [acq_pkg::sample_w-1:0] tp_data,
	output logic                         tp_vld
);

	logic [23:0]                  tp_period;
	logic [23:0]                  cnt_cycle;
	logic                         period_vld;
	logic [23:0]                  base_q;
	logic [7:0]                   step_q;
	logic                         cfg_tp_change;
	logic [acq_pkg::sample_w-1:0] step_ext;
	logic [acq_pkg::sample_w-1:0] ramp_data;
	logic [acq_pkg::sample_w-1:0] ident_data;

	// ------------------
	// Period counter
	assign tp_period  = acq_pkg::tp_period_base(cfg_sample) / 24'(period_div);
	assign period_vld = (cnt_cycle >= tp_period - 24'd1);	// >= so a shorter period wraps at once

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			cnt_cycle <= '0;
		else if (syn_vld || period_vld)
			cnt_cycle <= '0;
		else
			cnt_cycle <= cnt_cycle + 24'd1;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			tp_vld <= 1'b0;
		else
			tp_vld <= period_vld;
	end

	// ------------------
	// Ramp, reloads when base or step is rewritten
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			base_q <= '0;
			step_q <= '0;
		end else begin
			base_q <= cfg_tp_base;
			step_q <= cfg_tp_step;
		end
	end

	assign cfg_tp_change = (base_q != cfg_tp_base) || (step_q != cfg_tp_step);
	assign step_ext      = {{(acq_pkg::sample_w-8){1'b0}}, cfg_tp_step};

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			ramp_data <= '0;
		else if (cfg_tp_change)
			ramp_data <= cfg_tp_base;
		else if (period_vld)
			ramp_data <= ramp_data + step_ext;	// Wraps at 24 bits
	end

	// Identity word per module slot
	always_comb begin
		case (mod_id[1:0])
			2'd1:    ident_data = 24'h111111;
			2'd2:    ident_data = 24'h222222;
			2'd3:    ident_data = 24'h333333;
			default: ident_data = 24'h999999;
		endcase
	end

	always_comb begin
		case (cfg_ad_tp)
			acq_pkg::tp_ident: tp_data = ident_data;
			acq_pkg::tp_ramp:  tp_data = ramp_data;
			acq_pkg::tp_fixed: tp_data = cfg_ad_fix;
			default:           tp_data = acq_pkg::tp_marker;
		endcase
	end

endmodule

/* rtl/ad_capture.sv */
// ------------------
// Live ADC capture and live/pattern select into the sample output
// ------------------
`timescale 1ns/1ps

module ad_capture (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  logic [acq_pkg::sample_w-1:0] adc_data,
	input  logic                         adc_drdy,	// Asynchronous strobe
	input  logic [7:0]                   cfg_ad_tp,
	input  logic [acq_pkg::sample_w-1:0] tp_data,
	input  logic                         tp_vld,
	output logic [acq_pkg::sample_w-1:0] smp_data,
	output logic                         smp_vld
);

	logic                         drdy_s1;
	logic                         drdy_s2;
	logic                         drdy_s3;
	logic                         drdy_rise;
	logic [acq_pkg::sample_w-1:0] cap_data;
	logic                         cap_vld;
	logic                         live_mode;

	// ------------------
	// Strobe synchronizer and edge detect
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			drdy_s1 <= 1'b0;
			drdy_s2 <= 1'b0;
			drdy_s3 <= 1'b0;
		end else begin
			drdy_s1 <= adc_drdy;
			drdy_s2 <= drdy_s1;
			drdy_s3 <= drdy_s2;	// Previous value for edge detect
		end
	end

	assign drdy_rise = drdy_s2 & ~drdy_s3;

	// adc_data is stable while the strobe is high, safe to take here
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			cap_vld <= 1'b0;
		else
			cap_vld <= drdy_rise;
	end

	always_ff @(posedge clk_sys) begin
		if (drdy_rise)
			cap_data <= adc_data;
	end

	// ------------------
	// Output select and register
	assign live_mode = (cfg_ad_tp == acq_pkg::tp_live);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			smp_vld <= 1'b0;
		else
			smp_vld <= live_mode ? cap_vld : tp_vld;
	end

	always_ff @(posedge clk_sys) begin
		if (live_mode) begin
			if (cap_vld)
				smp_data <= cap_data;
		end else if (tp_vld) begin
			smp_data <= tp_data;	// Pattern word of this period
		end
	end

endmodule

/* rtl/ad_acq_top.sv */
// ------------------
// Channel acquisition front end, register block plus sample path
// ------------------
`timescale 1ns/1ps

module ad_acq_top #(
	parameter int period_div = 1	// 1 in hardware, larger for short sim periods
) (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	// Host AXI4-Lite
	input  logic [acq_pkg::axil_aw-1:0]   s_awaddr,
	input  logic                          s_awvalid,
	output logic                          s_awready,
	input  logic [acq_pkg::axil_dw-1:0]   s_wdata,
	input  logic [acq_pkg::axil_dw/8-1:0] s_wstrb,
	input  logic                          s_wvalid,
	output logic                          s_wready,
	output logic [1:0]                    s_bresp,
	output logic                          s_bvalid,
	input  logic                          s_bready,
	input  logic [acq_pkg::axil_aw-1:0]   s_araddr,
	input  logic                          s_arvalid,
	output logic                          s_arready,
	output logic [acq_pkg::axil_dw-1:0]   s_rdata,
	output logic [1:0]                    s_rresp,
	output logic                          s_rvalid,
	input  logic                          s_rready,
	// Sync and ADC
	input  logic                          syn_vld,
	input  logic [acq_pkg::sample_w-1:0]  adc_data,
	input  logic                          adc_drdy,
	// Sample stream, no back-pressure
	output logic [acq_pkg::sample_w-1:0]  smp_data,
	output logic                          smp_vld
);

	logic [7:0]                   cfg_ad_tp;
	logic [7:0]                   cfg_sample;
	logic [5:0]                   mod_id;
	logic [23:0]                  cfg_ad_fix;
	logic [23:0]                  cfg_tp_base;
	logic [7:0]                   cfg_tp_step;
	logic [acq_pkg::sample_w-1:0] tp_data;
	logic                         tp_vld;

	acq_cfg_regs u_regs (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.s_awaddr    (s_awaddr),
		.s_awvalid   (s_awvalid),
		.s_awready   (s_awready),
		.s_wdata     (s_wdata),
		.s_wstrb     (s_wstrb),
		.s_wvalid    (s_wvalid),
		.s_wready    (s_wready),
		.s_bresp     (s_bresp),
		.s_bvalid    (s_bvalid),
		.s_bready    (s_bready),
		.s_araddr    (s_araddr),
		.s_arvalid   (s_arvalid),
		.s_arready   (s_arready),
		.s_rdata     (s_rdata),
		.s_rresp     (s_rresp),
		.s_rvalid    (s_rvalid),
		.s_rready    (s_rready),
		.cfg_ad_tp   (cfg_ad_tp),
		.cfg_sample  (cfg_sample),
		.mod_id      (mod_id),
		.cfg_ad_fix  (cfg_ad_fix),
		.cfg_tp_base (cfg_tp_base),
		.cfg_tp_step (cfg_tp_step)
	);

	ad_tp #(
		.period_div (period_div)
	) u_tp (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.syn_vld     (syn_vld),
		.cfg_sample  (cfg_sample),
		.cfg_ad_tp   (cfg_ad_tp),
		.mod_id      (mod_id),
		.cfg_ad_fix  (cfg_ad_fix),
		.cfg_tp_base (cfg_tp_base),
		.cfg_tp_step (cfg_tp_step),
		.tp_data     (tp_data),
		.tp_vld      (tp_vld)
	);

	ad_capture u_cap (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.adc_data  (adc_data),
		.adc_drdy  (adc_drdy),
		.cfg_ad_tp (cfg_ad_tp),
		.tp_data   (tp_data),
		.tp_vld    (tp_vld),
		.smp_data  (smp_data),
		.smp_vld   (smp_vld)
	);

endmodule

/* sim/tb_axil_tasks.svh */
// --------------------
// AXI4-Lite host tasks and error counters
// Included in the testbench module body after its signal declarations
// --------------------
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

int err_cnt = 0;
int chk_cnt = 0;
localparam int hs_limit = 16;	// Cycles allowed for any ready or valid

// AW and W presented together, response taken as soon as it shows
task automatic write_reg(input logic [acq_pkg::axil_aw-1:0] addr,
		input logic [acq_pkg::axil_dw-1:0] data, input logic [3:0] strb);
	int n;
	@(posedge clk_sys);
	#2;
	s_awaddr  = addr;
	s_awvalid = 1'b1;
	s_wdata   = data;
	s_wstrb   = strb;
	s_wvalid  = 1'b1;
	s_bready  = 1'b1;
	n = 0;
	do begin
		@(posedge clk_sys);
		n++;
	end while (!s_awready && n < hs_limit);
	if (!s_awready) begin
		err_cnt++;
		$display("AXI write to 0x%0h was never accepted", addr);
	end
	#2;
	s_awvalid = 1'b0;
	s_wvalid  = 1'b0;
	n = 0;
	do begin
		@(posedge clk_sys);
		n++;
	end while (!s_bvalid && n < hs_limit);
	if (!s_bvalid) begin
		err_cnt++;
		$display("AXI write to 0x%0h got no response", addr);
	end
	#2;
	s_bready = 1'b0;
endtask

task automatic read_reg(input logic [acq_pkg::axil_aw-1:0] addr,
		output logic [acq_pkg::axil_dw-1:0] data);
	int n;
	@(posedge clk_sys);
	#2;
	s_araddr  = addr;
	s_arvalid = 1'b1;
	s_rready  = 1'b1;
	n = 0;
	do begin
		@(posedge clk_sys);
		n++;
	end while (!s_arready && n < hs_limit);
	if (!s_arready) begin
		err_cnt++;
		$display("AXI read of 0x%0h was never accepted", addr);
	end
	#2;
	s_arvalid = 1'b0;
	n = 0;
	do begin
		@(posedge clk_sys);
		n++;
	end while (!s_rvalid && n < hs_limit);
	if (!s_rvalid) begin
		err_cnt++;
		$display("AXI read of 0x%0h returned no data", addr);
	end
	data = s_rdata;	// Sampled on the edge that completes the beat
	#2;
	s_rready = 1'b0;
endtask

`endif

/* sim/tb_ad_acq.sv */
// --------------------
// Testbench for the channel acquisition front end
// Programs it over AXI4-Lite, drives sync and ADC strobes, checks the stream
// --------------------
`timescale 1ns/1ps

module tb_ad_acq;

	localparam int  clk_half     = 10;
	localparam real clk_per      = 20.0;
	localparam int  period_div   = 1000;
	localparam int  max_period   = 100;	// Longest period used, code 10
	localparam int  test_periods = 55;	// Sum over all tests, in sample periods
	localparam int  wd_cycles    = test_periods * max_period * 2 + 1000;
	localparam int  sample_limit = 2 * max_period + 10;

	logic                          clk_sys;
	logic                          rst_n;
	logic [acq_pkg::axil_aw-1:0]   s_awaddr;
	logic                          s_awvalid;
	logic                          s_awready;
	logic [acq_pkg::axil_dw-1:0]   s_wdata;
	logic [acq_pkg::axil_dw/8-1:0] s_wstrb;
	logic                          s_wvalid;
	logic                          s_wready;
	logic [1:0]                    s_bresp;
	logic                          s_bvalid;
	logic                          s_bready;
	logic [acq_pkg::axil_aw-1:0]   s_araddr;
	logic                          s_arvalid;
	logic                          s_arready;
	logic [acq_pkg::axil_dw-1:0]   s_rdata;
	logic [1:0]                    s_rresp;
	logic                          s_rvalid;
	logic                          s_rready;
	logic                          syn_vld;
	logic [acq_pkg::sample_w-1:0]  adc_data;
	logic                          adc_drdy;
	logic [acq_pkg::sample_w-1:0]  smp_data;
	logic                          smp_vld;
	real                           drdy_time;
	real                           rise_time;

	`include "tb_axil_tasks.svh"

	ad_acq_top #(
		.period_div (period_div)
	) u_dut (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.s_awaddr  (s_awaddr),
		.s_awvalid (s_awvalid),
		.s_awready (s_awready),
		.s_wdata   (s_wdata),
		.s_wstrb   (s_wstrb),
		.s_wvalid  (s_wvalid),
		.s_wready  (s_wready),
		.s_bresp   (s_bresp),
		.s_bvalid  (s_bvalid),
		.s_bready  (s_bready),
		.s_araddr  (s_araddr),
		.s_arvalid (s_arvalid),
		.s_arready (s_arready),
		.s_rdata   (s_rdata),
		.s_rresp   (s_rresp),
		.s_rvalid  (s_rvalid),
		.s_rready  (s_rready),
		.syn_vld   (syn_vld),
		.adc_data  (adc_data),
		.adc_drdy  (adc_drdy),
		.smp_data  (smp_data),
		.smp_vld   (smp_vld)
	);

	always #clk_half clk_sys = ~clk_sys;

	always @(posedge smp_vld) rise_time = $realtime;	// For live latency

	// --------------------
	// Protocol and stream rules, checked every cycle
	assert property (@(posedge clk_sys) disable iff (!rst_n) s_bvalid |-> s_bresp == 2'b00)
		else begin
			err_cnt++;
			$display("CHECK FAILED s_bresp got 0x%0h expected 0x0", s_bresp);
		end

	assert property (@(posedge clk_sys) disable iff (!rst_n) s_rvalid |-> s_rresp == 2'b00)
		else begin
			err_cnt++;
			$display("CHECK FAILED s_rresp got 0x%0h expected 0x0", s_rresp);
		end

	assert property (@(posedge clk_sys) disable iff (!rst_n) s_awready == s_wready)
		else begin
			err_cnt++;
			$display("CHECK FAILED s_wready got 0x%0h expected 0x%0h", s_wready, s_awready);
		end

	assert property (@(posedge clk_sys) disable iff (!rst_n) smp_vld |=> !smp_vld)
		else begin
			err_cnt++;
			$display("smp_vld stayed high for more than one cycle");
		end

	// --------------------
	// Helpers
	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		chk_cnt++;
		assert (got === exp)
			else begin
				err_cnt++;
				$display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
			end
	endtask

	function automatic logic [31:0] ctrl_word(input logic [7:0] pat, input logic [7:0] code,
			input logic [5:0] id);
		return {10'h0, id, code, pat};
	endfunction

	// cyc counts edges up to the one that sees smp_vld high
	task automatic wait_sample(input int limit, output logic [23:0] data, output int cyc);
		cyc = 0;
		data = '0;
		do begin
			@(posedge clk_sys);
			cyc++;
		end while (!smp_vld && cyc < limit);
		if (smp_vld) begin
			data = smp_data;
		end else begin
			err_cnt++;
			$display("No sample arrived within %0d cycles", limit);
		end
	endtask

	task automatic pulse_sync();
		@(posedge clk_sys);
		#2 syn_vld = 1'b1;
		@(posedge clk_sys);	// Edge that samples the pulse
		#2 syn_vld = 1'b0;
	endtask

	task automatic expect_words(input logic [31:0] ctrl, input logic [23:0] exp);
		logic [23:0] word;
		int          cyc;
		write_reg(acq_pkg::reg_ctrl, ctrl, 4'hf);
		repeat (3) begin
			wait_sample(sample_limit, word, cyc);
			check_val("smp_data", {8'h0, word}, {8'h0, exp});
		end
	endtask

	// --------------------
	// Tests
	task automatic regs_readback();
		logic [31:0] shadow [4];
		logic [31:0] mask [4];
		logic [31:0] wdat;
		logic [31:0] rdat;
		logic [3:0]  strb;
		mask[0] = 32'h003f_ffff;
		mask[1] = 32'h00ff_ffff;
		mask[2] = 32'h00ff_ffff;
		mask[3] = 32'h0000_00ff;
		for (int r = 0; r < 4; r++)
			shadow[r] = '0;	// Reset value
		for (int pass = 0; pass < 4; pass++) begin
			for (int r = 0; r < 4 && pass > 0; r++) begin
				wdat = $urandom();
				strb = (pass == 1) ? 4'hf : 4'($urandom());
				write_reg(4'(r * 4 + $urandom_range(0, 3)), wdat, strb);
				for (int b = 0; b < 4; b++)
					if (strb[b])
						shadow[r][b*8 +: 8] = wdat[b*8 +: 8];
			end
			for (int r = 0; r < 4; r++) begin
				read_reg(4'(r * 4 + $urandom_range(0, 3)), rdat);
				check_val("s_rdata", rdat, shadow[r] & mask[r]);
			end
		end
	endtask

	task automatic ident_fixed_marker();
		logic [23:0] fix;
		expect_words(ctrl_word(acq_pkg::tp_ident, 8'd20, 6'd0), 24'h999999);
		expect_words(ctrl_word(acq_pkg::tp_ident, 8'd20, 6'(1 + 4 * $urandom_range(0, 15))),
			24'h111111);	// Upper id bits do not matter
		expect_words(ctrl_word(acq_pkg::tp_ident, 8'd20, 6'd2), 24'h222222);
		expect_words(ctrl_word(acq_pkg::tp_ident, 8'd20, 6'd3), 24'h333333);
		fix = 24'($urandom());
		write_reg(acq_pkg::reg_fix, {8'($urandom()), fix}, 4'hf);
		expect_words(ctrl_word(acq_pkg::tp_fixed, 8'd20, 6'd0), fix);
		expect_words(ctrl_word(8'd7, 8'd20, 6'd0), 24'h555555);
	endtask

	task automatic ramp_sequence();
		logic [23:0] word;
		logic [23:0] expect_word;
		logic [23:0] base;
		logic [7:0]  step;
		int          cyc;
		step = 8'($urandom_range(1, 255));
		write_reg(acq_pkg::reg_ctrl, ctrl_word(acq_pkg::tp_ramp, 8'd20, 6'd0), 4'hf);
		write_reg(acq_pkg::reg_tp_step, {24'h0, step}, 4'hf);
		for (int run = 0; run < 2; run++) begin
			if (run == 0)
				base = 24'($urandom());
			else
				base = {16'hffff, 8'($urandom_range(256 - step, 255))};	// First step wraps
			wait_sample(sample_limit, word, cyc);
			pulse_sync();	// Keeps the reload clear of a period edge
			write_reg(acq_pkg::reg_tp_base, {8'h0, base}, 4'hf);
			expect_word = base + {16'h0, step};
			wait_sample(sample_limit, word, cyc);
			check_val("smp_data", {8'h0, word}, {8'h0, expect_word});
			repeat (4) begin
				expect_word = expect_word + {16'h0, step};	// Modulo 2^24
				wait_sample(sample_limit, word, cyc);
				check_val("smp_data", {8'h0, word}, {8'h0, expect_word});
			end
		end
	endtask

	task automatic period_and_sync();
		logic [23:0] word;
		logic [7:0]  codes [3];
		int          periods [3];
		int          cyc;
		codes[0]   = 8'd20;
		codes[1]   = 8'd10;
		periods[0] = 50_000 / period_div;
		periods[1] = 100_000 / period_div;
		periods[2] = 50_000 / period_div;	// Undefined code, fastest rate
		do
			codes[2] = 8'($urandom());
		while (codes[2] inside {8'd1, 8'd2, 8'd5, 8'd10, 8'd20});
		for (int i = 0; i < 3; i++) begin
			write_reg(acq_pkg::reg_ctrl, ctrl_word(acq_pkg::tp_fixed, codes[i], 6'd0), 4'hf);
			wait_sample(sample_limit, word, cyc);	// First gap may be short
			repeat (2) begin
				wait_sample(sample_limit, word, cyc);
				check_val("smp_vld spacing", cyc, periods[i]);
			end
		end
		write_reg(acq_pkg::reg_ctrl, ctrl_word(acq_pkg::tp_fixed, 8'd20, 6'd0), 4'hf);
		repeat (2) begin
			wait_sample(sample_limit, word, cyc);
			repeat ($urandom_range(0, 15)) @(posedge clk_sys);
			pulse_sync();
			wait_sample(sample_limit, word, cyc);
			// Seen one edge after it rises
			check_val("smp_vld after syn_vld", cyc - 1, periods[0] + 1);
		end
	endtask

	task automatic live_capture();
		logic [23:0] word;
		logic [23:0] adc_word;
		real         lat;
		int          cyc;
		write_reg(acq_pkg::reg_ctrl, ctrl_word(acq_pkg::tp_live, 8'd20, 6'd0), 4'hf);
		repeat (8) begin
			adc_word = 24'($urandom());
			@(posedge clk_sys);
			#2;
			adc_data  = adc_word;
			adc_drdy  = 1'b1;
			drdy_time = $realtime;
			repeat ($urandom_range(1, 3)) @(posedge clk_sys);
			#2 adc_drdy = 1'b0;
			wait_sample(8, word, cyc);
			check_val("smp_data", {8'h0, word}, {8'h0, adc_word});
			lat = rise_time - drdy_time;
			chk_cnt++;
			assert (lat >= 3.0 * clk_per && lat <= 4.0 * clk_per)
				else begin
					err_cnt++;
					$display("CHECK FAILED smp_vld latency got 0x%0h ns expected 3 to 4 cycles",
						int'(lat));
				end
			repeat ($urandom_range(2, 6)) @(posedge clk_sys);
		end
	endtask

	// --------------------
	// Main sequence
	initial begin
		void'($urandom(32'he685_a3c9));
		clk_sys   = 1'b0;
		rst_n     = 1'b0;
		s_awaddr  = '0;
		s_awvalid = 1'b0;
		s_wdata   = '0;
		s_wstrb   = '0;
		s_wvalid  = 1'b0;
		s_bready  = 1'b0;
		s_araddr  = '0;
		s_arvalid = 1'b0;
		s_rready  = 1'b0;
		syn_vld   = 1'b0;
		adc_data  = '0;
		adc_drdy  = 1'b0;
		repeat (4) @(posedge clk_sys);
		#2 rst_n = 1'b1;
		check_val("ready and valid outputs after reset",
			{26'h0, s_awready, s_wready, s_bvalid, s_arready, s_rvalid, smp_vld}, 32'h0);
		regs_readback();
		ident_fixed_marker();
		ramp_sequence();
		period_and_sync();
		live_capture();
		$display("Checks run %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		repeat (wd_cycles) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, tests did not finish", wd_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+sim
rtl/acq_pkg.sv
rtl/acq_cfg_regs.sv
rtl/ad_tp.sv
rtl/ad_capture.sv
rtl/ad_acq_top.sv
sim/tb_ad_acq.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the acquisition front end testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f verilog.f --top-module tb_ad_acq -o tb_ad_acq
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_ad_acq > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
	echo "Simulation reported failures, see $LOG"
	exit 1
fi

echo "Simulation passed"
exit 0
